// ==== logic/tia_color_pkg.sv ====
`default_nettype none

package tia_color_pkg;

  // Stored color holds write data bits 7..1, bit 0 is ignored by the chip
  localparam int COLOR_W = 7;

  // Low three stored bits drive luminance, the high four drive hue
  localparam int LUM_W = 3;
  localparam int HUE_W = 4;

  // Register addresses on the CPU write bus
  typedef enum logic [5:0] {
    COLUP0 = 6'd6,
    COLUP1 = 6'd7,
    COLUPF = 6'd8,
    COLUBK = 6'd9,
    CTRLPF = 6'd10
  } color_addr_e;

  // Source that wins the pixel
  // Each value except SRC_BLANK names the color register that is shown
  typedef enum logic [2:0] {
    SRC_BLANK,
    SRC_BK,
    SRC_PF,
    SRC_P1,
    SRC_P0
  } pixel_src_e;

endpackage

`default_nettype wire

// ==== logic/tia_color_bank_if.sv ====
`default_nettype none

interface tia_color_bank_if;

  // Stored colors, one per color register
  logic [tia_color_pkg::COLOR_W-1:0] col_p0;
  logic [tia_color_pkg::COLOR_W-1:0] col_p1;
  logic [tia_color_pkg::COLOR_W-1:0] col_pf;
  logic [tia_color_pkg::COLOR_W-1:0] col_bk;

  // Control bits kept from CTRLPF
  logic score;
  logic pfp;

  modport bank (
    output col_p0, col_p1, col_pf, col_bk,
    output score, pfp
  );

  modport user (
    input col_p0, col_p1, col_pf, col_bk,
    input score, pfp
  );

endinterface

`default_nettype wire

// ==== logic/tia_color_regs.sv ====
`default_nettype none

module tia_color_regs (
  input  wire                        clkp,
  input  wire                        rst_n,
  input  wire                        wr,
  input  tia_color_pkg::color_addr_e addr,
  input  wire [7:0]                  data,
  tia_color_bank_if.bank             bank
);

  logic [tia_color_pkg::COLOR_W-1:0] col_p0;
  logic [tia_color_pkg::COLOR_W-1:0] col_p1;
  logic [tia_color_pkg::COLOR_W-1:0] col_pf;
  logic [tia_color_pkg::COLOR_W-1:0] col_bk;
  logic                              score;
  logic                              pfp;

  // The real chip latches these on the write strobe but here they load on the clock edge
  always_ff @(posedge clkp or negedge rst_n) begin
    if (!rst_n) begin
      col_p0 <= '0;
      col_p1 <= '0;
      col_pf <= '0;
      col_bk <= '0;
      score  <= 1'b0;
      pfp    <= 1'b0;
    end else if (wr) begin
      case (addr)
        tia_color_pkg::COLUP0: col_p0 <= data[7:1];
        tia_color_pkg::COLUP1: col_p1 <= data[7:1];
        tia_color_pkg::COLUPF: col_pf <= data[7:1];
        tia_color_pkg::COLUBK: col_bk <= data[7:1];
        tia_color_pkg::CTRLPF: begin
          // Reflect and ball size bits belong to other blocks
          score <= data[1];
          pfp   <= data[2];
        end
        default: begin
        end
      endcase
    end
  end

  assign bank.col_p0 = col_p0;
  assign bank.col_p1 = col_p1;
  assign bank.col_pf = col_pf;
  assign bank.col_bk = col_bk;
  assign bank.score  = score;
  assign bank.pfp    = pfp;

  // Score and pfp share one register, so they count as one
  a_single_target: assert property (
    @(posedge clkp) disable iff (!rst_n)
    $onehot0({$changed(col_p0), $changed(col_p1), $changed(col_pf),
              $changed(col_bk), $changed(score) || $changed(pfp)})
  ) else $error("write changed more than one color register");

endmodule

`default_nettype wire

// ==== logic/tia_color_priority.sv ====
`default_nettype none

module tia_color_priority (
  input  wire                       clkp,
  input  wire                       rst_n,
  input  wire                       p0,
  input  wire                       m0,
  input  wire                       p1,
  input  wire                       m1,
  input  wire                       pf,
  input  wire                       bl,
  input  wire                       blank,
  input  wire                       cntd,
  tia_color_bank_if.user            bank,
  output tia_color_pkg::pixel_src_e src
);

  logic left_half;
  logic pf_or_bl;
  logic score_mode;
  logic score_p0;
  logic score_p1;
  logic any_p0;
  logic any_p1;

  // Half-screen tracker
  // Blank at the start of a line means the left half and the center strobe ends it
  always_ff @(posedge clkp or negedge rst_n) begin
    if (!rst_n) begin
      left_half <= 1'b1;
    end else if (blank) begin
      left_half <= 1'b1;
    end else if (cntd) begin
      left_half <= 1'b0;
    end
  end

  assign pf_or_bl = pf | bl;

  // In score mode playfield bits take the player color of their half
  assign score_mode = bank.score & ~bank.pfp;
  assign score_p0   = score_mode & pf & left_half;
  assign score_p1   = score_mode & pf & ~left_half;

  assign any_p0 = p0 | m0 | score_p0;
  assign any_p1 = p1 | m1 | score_p1;

  always_comb begin
    if (blank) begin
      src = tia_color_pkg::SRC_BLANK;
    end else if (bank.pfp && pf_or_bl) begin
      src = tia_color_pkg::SRC_PF;
    end else if (any_p0) begin
      src = tia_color_pkg::SRC_P0;
    end else if (any_p1) begin
      src = tia_color_pkg::SRC_P1;
    end else if (pf_or_bl) begin
      // Ball keeps the playfield color even in score mode
      src = tia_color_pkg::SRC_PF;
    end else begin
      src = tia_color_pkg::SRC_BK;
    end
  end

  a_blank_wins: assert property (
    @(posedge clkp) disable iff (!rst_n)
    blank |-> src == tia_color_pkg::SRC_BLANK
  ) else $error("blank did not select the blank source");

endmodule

`default_nettype wire

// ==== logic/tia_color_output.sv ====
`default_nettype none

module tia_color_output (
  input  wire                                clkp,
  input  wire                                rst_n,
  input  tia_color_pkg::pixel_src_e          src,
  tia_color_bank_if.user                     bank,
  output logic                               blk_bar,
  output logic [tia_color_pkg::LUM_W-1:0]    lum,
  output logic [tia_color_pkg::HUE_W-1:0]    hue
);

  logic [tia_color_pkg::COLOR_W-1:0] color_sel;

  // Color mux that forces black while blanking
  always_comb begin
    case (src)
      tia_color_pkg::SRC_P0: color_sel = bank.col_p0;
      tia_color_pkg::SRC_P1: color_sel = bank.col_p1;
      tia_color_pkg::SRC_PF: color_sel = bank.col_pf;
      tia_color_pkg::SRC_BK: color_sel = bank.col_bk;
      default:               color_sel = '0;
    endcase
  end

  // Output register stage, one pixel clock behind the inputs
  always_ff @(posedge clkp or negedge rst_n) begin
    if (!rst_n) begin
      blk_bar <= 1'b0;
      lum     <= '0;
      hue     <= '0;
    end else begin
      blk_bar <= (src != tia_color_pkg::SRC_BLANK);
      lum     <= color_sel[tia_color_pkg::LUM_W-1:0];
      hue     <= color_sel[tia_color_pkg::COLOR_W-1:tia_color_pkg::LUM_W];
    end
  end

  a_blank_black: assert property (
    @(posedge clkp) disable iff (!rst_n)
    !blk_bar |-> lum == '0 && hue == '0
  ) else $error("nonzero color during blanking");

endmodule

`default_nettype wire

// ==== logic/tia_color_top.sv ====
`default_nettype none

module tia_color_top (
  input  wire       clkp,
  input  wire       rst_n,
  input  wire       wr,
  input  wire [5:0] addr,
  input  wire [7:0] data,
  input  wire       p0,
  input  wire       m0,
  input  wire       p1,
  input  wire       m1,
  input  wire       pf,
  input  wire       bl,
  input  wire       blank,
  input  wire       cntd,
  output wire       blk_bar,
  output wire [2:0] lum,
  output wire [3:0] hue
);

  tia_color_pkg::pixel_src_e src;

  tia_color_bank_if bank_if ();

  tia_color_regs u_regs (
    .clkp  (clkp),
    .rst_n (rst_n),
    .wr    (wr),
    .addr  (tia_color_pkg::color_addr_e'(addr)),
    .data  (data),
    .bank  (bank_if.bank)
  );

  tia_color_priority u_priority (
    .clkp  (clkp),
    .rst_n (rst_n),
    .p0    (p0),
    .m0    (m0),
    .p1    (p1),
    .m1    (m1),
    .pf    (pf),
    .bl    (bl),
    .blank (blank),
    .cntd  (cntd),
    .bank  (bank_if.user),
    .src   (src)
  );

  tia_color_output u_output (
    .clkp    (clkp),
    .rst_n   (rst_n),
    .src     (src),
    .bank    (bank_if.user),
    .blk_bar (blk_bar),
    .lum     (lum),
    .hue     (hue)
  );

endmodule

`default_nettype wire

// ==== tests/tia_color_tb.sv ====
`default_nettype none

module tia_color_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MAX_VEC = 256;
  localparam int NUM_FIELDS = 15;

  logic       clkp;
  logic       rst_n;
  logic       wr;
  logic [5:0] addr;
  logic [7:0] data;
  logic       p0;
  logic       m0;
  logic       p1;
  logic       m1;
  logic       pf;
  logic       bl;
  logic       blank;
  logic       cntd;
  wire        blk_bar;
  wire  [2:0] lum;
  wire  [3:0] hue;

  // Pixel bits are packed as p0 m0 p1 m1 pf bl blank cntd, p0 in the top bit
  int         vec_test [MAX_VEC];
  logic       vec_wr   [MAX_VEC];
  logic [5:0] vec_addr [MAX_VEC];
  logic [7:0] vec_data [MAX_VEC];
  logic [7:0] vec_pix  [MAX_VEC];
  logic       vec_blk  [MAX_VEC];
  logic [2:0] vec_lum  [MAX_VEC];
  logic [3:0] vec_hue  [MAX_VEC];
  int         num_vec;
  bit         file_ok;
  bit         loaded;
  int         errors;
  int         test_errors;
  int         tests_passed;
  int         tests_failed;

  tia_color_top UUT (
    .clkp    (clkp),
    .rst_n   (rst_n),
    .wr      (wr),
    .addr    (addr),
    .data    (data),
    .p0      (p0),
    .m0      (m0),
    .p1      (p1),
    .m1      (m1),
    .pf      (pf),
    .bl      (bl),
    .blank   (blank),
    .cntd    (cntd),
    .blk_bar (blk_bar),
    .lum     (lum),
    .hue     (hue)
  );

  always #4 clkp = ~clkp;

  task automatic check_value(input logic [7:0] actual, input logic [7:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("mismatch at %0d ns: %s is %0h, expected %0h", $time, what, actual, expected);
      errors++;
      test_errors++;
    end
  endtask

  task automatic load_patterns();
    int    fd;
    int    count;
    string line;
    int    f [NUM_FIELDS];
    fd = $fopen("tests/tia_color_patterns.txt", "r");
    if (fd == 0) begin
      $display("Could not open the pattern file tests/tia_color_patterns.txt");
      errors++;
      return;
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      count = $sscanf(line, "%d %d %h %h %d %d %d %d %d %d %d %d %d %d %h",
                      f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                      f[8], f[9], f[10], f[11], f[12], f[13], f[14]);
      if (count != NUM_FIELDS || num_vec == MAX_VEC) begin
        $display("Pattern line could not be read: %s", line);
        errors++;
      end else begin
        vec_test[num_vec] = f[0];
        vec_wr[num_vec]   = f[1][0];
        vec_addr[num_vec] = f[2][5:0];
        vec_data[num_vec] = f[3][7:0];
        vec_pix[num_vec]  = {f[4][0], f[5][0], f[6][0], f[7][0],
                             f[8][0], f[9][0], f[10][0], f[11][0]};
        vec_blk[num_vec]  = f[12][0];
        vec_lum[num_vec]  = f[13][2:0];
        vec_hue[num_vec]  = f[14][3:0];
        num_vec++;
      end
    end
    $fclose(fd);
    if (num_vec == 0) begin
      $display("The pattern file holds no vectors");
      errors++;
    end else begin
      file_ok = 1'b1;
    end
  endtask

  task automatic apply_vector(input int i);
    wr   = vec_wr[i];
    addr = vec_addr[i];
    data = vec_data[i];
    {p0, m0, p1, m1, pf, bl, blank, cntd} = vec_pix[i];
  endtask

  task automatic check_outputs(input int t, input logic exp_blk, input logic [2:0] exp_lum,
                               input logic [3:0] exp_hue);
    check_value({7'd0, blk_bar}, {7'd0, exp_blk}, $sformatf("test %0d blk_bar", t));
    check_value({5'd0, lum}, {5'd0, exp_lum}, $sformatf("test %0d lum", t));
    check_value({4'd0, hue}, {4'd0, exp_hue}, $sformatf("test %0d hue", t));
  endtask

  task automatic report_test(input int t);
    if (test_errors == 0) begin
      $display("test %0d passed", t);
      tests_passed++;
    end else begin
      $display("test %0d failed with %0d mismatches", t, test_errors);
      tests_failed++;
    end
    test_errors = 0;
  endtask

  initial begin
    clkp  = 1'b0;
    rst_n = 1'b0;
    wr    = 1'b0;
    addr  = '0;
    data  = '0;
    {p0, m0, p1, m1, pf, bl, blank, cntd} = '0;
    load_patterns();
    loaded = 1'b1;
    if (file_ok) begin
      repeat (3) @(posedge clkp);
      #1;
      rst_n = 1'b1;
      // Reset values count toward the first test
      check_outputs(vec_test[0], 1'b0, 3'd0, 4'd0);
      apply_vector(0);
      for (int i = 1; i <= num_vec; i++) begin
        @(posedge clkp);
        #1;
        check_outputs(vec_test[i - 1], vec_blk[i - 1], vec_lum[i - 1], vec_hue[i - 1]);
        if (i == num_vec || vec_test[i] != vec_test[i - 1]) begin
          report_test(vec_test[i - 1]);
        end
        if (i < num_vec) begin
          apply_vector(i);
        end
      end
    end
    $display("%0d tests passed, %0d tests failed, %0d errors", tests_passed, tests_failed,
             errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Four times the nominal run length leaves ample margin
  initial begin
    wait (loaded);
    #(num_vec * 32 + 200);
    $display("Timeout: the run did not end within %0d ns", num_vec * 32 + 200);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tia_color.f ====
logic/tia_color_pkg.sv
logic/tia_color_bank_if.sv
logic/tia_color_regs.sv
logic/tia_color_priority.sv
logic/tia_color_output.sv
logic/tia_color_top.sv
tests/tia_color_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the color section testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -f "$LOG"
verilator --binary --timing --assert --timescale 1ns/100ps -f tia_color.f \
  --top-module tia_color_tb -o tia_color_sim > "$LOG" 2>&1 &&
  ./obj_dir/tia_color_sim >> "$LOG" 2>&1 ||
  echo "Simulation failed" >> "$LOG"
cat "$LOG"
grep -q "Simulation failed" "$LOG" &&
  { echo "FAIL: see $LOG"; exit 1; } ||
  { echo "PASS"; exit 0; }

// ==== tests/tia_color_patterns.txt ====
# test wr addr data p0 m0 p1 m1 pf bl blank cntd, then expected blk_bar lum hue
# addr, data and hue are hex, one line per pixel clock, outputs checked one clock later
1 0 00 00 0 0 0 0 0 0 1 0 0 0 0
1 1 09 2a 0 0 0 0 0 0 1 0 0 0 0
1 0 00 00 1 1 1 1 1 1 1 0 0 0 0
2 0 00 00 0 0 0 0 0 0 0 0 1 5 2
2 1 06 44 1 0 0 0 0 0 0 0 1 0 0
2 1 07 87 1 0 0 0 0 0 0 0 1 2 4
2 1 08 ce 0 0 1 0 0 0 0 0 1 3 8
2 1 0b ff 0 0 0 0 1 0 0 0 1 7 c
2 0 00 00 0 0 0 0 0 0 0 0 1 5 2
3 0 00 00 1 1 1 1 1 1 0 0 1 2 4
3 0 00 00 0 1 1 0 1 0 0 0 1 2 4
3 0 00 00 0 0 1 0 1 1 0 0 1 3 8
3 0 00 00 0 0 0 1 0 1 0 0 1 3 8
3 1 0a 04 0 0 0 0 0 0 0 0 1 5 2
4 0 00 00 1 0 1 0 1 0 0 0 1 7 c
4 0 00 00 0 1 0 0 0 1 0 0 1 7 c
4 0 00 00 0 0 1 0 0 0 0 0 1 3 8
4 1 0a 06 1 0 0 0 1 0 0 0 1 7 c
4 0 00 00 1 0 0 0 1 0 0 0 1 7 c
5 1 0a 02 0 0 0 0 0 0 1 0 0 0 0
5 0 00 00 0 0 0 0 1 0 0 0 1 2 4
5 0 00 00 0 0 0 0 0 1 0 0 1 7 c
5 0 00 00 0 0 0 0 0 0 0 1 1 5 2
5 0 00 00 0 0 0 0 1 0 0 0 1 3 8
5 0 00 00 0 0 0 0 0 1 0 0 1 7 c
5 0 00 00 1 0 0 0 1 0 0 0 1 2 4
